/* mmu_pkg.sv */
//################################################
// Sv32 MMU shared definitions
// Widths, privilege and access codes, PTE layout,
// page-fault causes and the virtual address view
//################################################

package mmu_pkg;

    localparam int xlen  = 32;
    localparam int vpn_w = 20;
    localparam int ppn_w = 20;

    // Request type, also the index into the {W, R, X} permission vector
    localparam logic [1:0] access_fetch = 2'd0;
    localparam logic [1:0] access_load  = 2'd1;
    localparam logic [1:0] access_store = 2'd2;
    localparam logic [1:0] access_none  = 2'd3;

    // Privilege levels
    localparam logic [1:0] priv_u = 2'd0;
    localparam logic [1:0] priv_s = 2'd1;
    localparam logic [1:0] priv_m = 2'd3;

    // PTE bit positions
    localparam int pte_v   = 0;
    localparam int pte_r   = 1;
    localparam int pte_w   = 2;
    localparam int pte_x   = 3;
    localparam int pte_u   = 4;
    localparam int pte_a   = 6;
    localparam int pte_d   = 7;
    localparam int pte_ppn = 10;

    // CSR fields
    localparam int mstatus_sum = 18;
    localparam int mstatus_mxr = 19;
    localparam int satp_mode   = 31;

    // Page-fault causes
    localparam logic [xlen-1:0] cause_fetch_pf = 32'd12;
    localparam logic [xlen-1:0] cause_load_pf  = 32'd13;
    localparam logic [xlen-1:0] cause_store_pf = 32'd15;

    // funct3 word size, used for PTE traffic and fetches
    localparam logic [2:0] mem_size_word = 3'b010;

    // One virtual address, seen by the walker or by the TLBs
    typedef union packed {
        struct packed {
            logic [9:0]  vpn1;
            logic [9:0]  vpn0;
            logic [11:0] offset;
        } walk;
        struct packed {
            logic [vpn_w-1:0] vpn;
            logic [11:0]      offset;
        } page;
    } sv32_vaddr_u;

endpackage

/* mmu_tlb.sv */
//################################################
// Direct-mapped TLB
// Combinational lookup, clocked fill and flush
//################################################

`timescale 1ns/100ps

module mmu_tlb import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             we,
    input  logic [vpn_w-1:0] lookup_vpn,
    input  logic [vpn_w-1:0] fill_vpn,
    input  logic [ppn_w-1:0] fill_ppn,
    output logic             hit,
    output logic [ppn_w-1:0] ppn
);

    localparam int idx_w = $clog2(TLB_ENTRIES);
    localparam int tag_w = vpn_w - idx_w;

    logic [TLB_ENTRIES-1:0] valid;
    logic [tag_w-1:0]       tag_mem [TLB_ENTRIES];
    logic [ppn_w-1:0]       ppn_mem [TLB_ENTRIES];
    logic [idx_w-1:0]       rd_idx;
    logic [idx_w-1:0]       wr_idx;
    logic [tag_w-1:0]       rd_tag;
    logic [tag_w-1:0]       wr_tag;

    // Low VPN bits pick the entry, the rest is the tag
    assign {rd_tag, rd_idx} = lookup_vpn;
    assign {wr_tag, wr_idx} = fill_vpn;

    assign hit = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign ppn = ppn_mem[rd_idx];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (we) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            tag_mem[wr_idx] <= wr_tag;
            ppn_mem[wr_idx] <= fill_ppn;
        end
    end

endmodule

/* mmu_pte_check.sv */
//################################################
// PTE permission check for one walk level
// Leaf detect, access rules and A/D update value
//################################################

`timescale 1ns/100ps

module mmu_pte_check import mmu_pkg::*; (
    input  logic [xlen-1:0] pte,
    input  logic [1:0]      req_type,
    input  logic [1:0]      priv,
    input  logic [xlen-1:0] mstatus,
    output logic            is_leaf,
    output logic            allowed,
    output logic [xlen-1:0] pte_updated
);

    logic       read_eff;
    logic [2:0] perm;
    logic       reserved;
    logic       priv_fail;
    logic       type_ok;

    // MXR lets executable pages be read
    assign read_eff = pte[pte_r] || (mstatus[mstatus_mxr] && pte[pte_x]);

    // Ordered so that the access code selects its own bit
    assign perm = {pte[pte_w], read_eff, pte[pte_x]};

    assign is_leaf = |perm;

    // Write without read is reserved, with or without X
    assign reserved = pte[pte_w] && !pte[pte_r];

    assign priv_fail = (priv == priv_s && pte[pte_u] && !mstatus[mstatus_sum]) ||
                       (priv == priv_u && !pte[pte_u]);

    assign type_ok = (req_type != access_none) && perm[req_type];

    assign allowed = !reserved && !priv_fail && type_ok;

    // Accessed always, dirty only on a store
    always_comb begin
        pte_updated        = pte;
        pte_updated[pte_a] = 1'b1;
        if (req_type == access_store) begin
            pte_updated[pte_d] = 1'b1;
        end
    end

endmodule

/* mmu_page_walker.sv */
//################################################
// Sv32 page walker
// Two-level PTE reads, A/D write-back, TLB refill
// and registered physical address on a TLB hit
//################################################

`timescale 1ns/100ps

module mmu_page_walker import mmu_pkg::*; (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic [1:0]        req_type,
    input  sv32_vaddr_u       vaddr,
    input  logic [xlen-1:0]   satp,
    input  logic              translate,
    input  logic              tlb_hit,
    input  logic [ppn_w-1:0]  tlb_ppn,
    input  logic              mem_busy,
    input  logic [xlen-1:0]   mem_rdata,
    output logic [xlen-1:0]   l1_pte,
    output logic [xlen-1:0]   l0_pte,
    input  logic              l1_leaf,
    input  logic              l1_ok,
    input  logic              l0_leaf,
    input  logic              l0_ok,
    input  logic [xlen-1:0]   l1_pte_upd,
    input  logic [xlen-1:0]   l0_pte_upd,
    output logic [xlen-1:0]   walk_addr,
    output logic [xlen-1:0]   walk_wdata,
    output logic              walk_re,
    output logic              walk_we,
    output logic [2:0]        fill_we,
    output logic [ppn_w-1:0]  fill_ppn,
    output logic [xlen-1:0]   paddr,
    output logic              paddr_valid,
    output logic              walk_busy,
    output logic              fault
);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_l1_rd   = 3'd1;
    localparam logic [2:0] st_l1_wait = 3'd2;
    localparam logic [2:0] st_l0_rd   = 3'd3;
    localparam logic [2:0] st_l0_wait = 3'd4;
    localparam logic [2:0] st_check   = 3'd5;
    localparam logic [2:0] st_update  = 3'd6;
    localparam logic [2:0] st_hit     = 3'd7;

    logic [2:0]       state;
    logic [xlen-1:0]  l1_addr;
    logic [xlen-1:0]  l0_addr;
    logic             chk_fail;
    logic [ppn_w-1:0] chk_ppn;
    logic [xlen-1:0]  chk_addr;
    logic [xlen-1:0]  chk_wdata;
    logic             chk_need_wr;
    logic             r_fail;
    logic             r_need_wr;
    logic [xlen-1:0]  r_waddr;
    logic [xlen-1:0]  r_wdata;
    logic [ppn_w-1:0] r_ppn;

    assign l1_addr = {satp[ppn_w-1:0], 12'b0} + {20'b0, vaddr.walk.vpn1, 2'b0};
    assign l0_addr = {l1_pte[pte_ppn +: ppn_w], 12'b0} + {20'b0, vaddr.walk.vpn0, 2'b0};

    // Level 1 first, then level 0; anything else is a fault
    always_comb begin
        chk_fail    = 1'b1;
        chk_ppn     = l0_pte[pte_ppn +: ppn_w];
        chk_addr    = l0_addr;
        chk_wdata   = l0_pte_upd;
        chk_need_wr = (l0_pte_upd != l0_pte);
        if (l1_pte[pte_v] && l1_leaf) begin
            // Superpage keeps VPN0 from the address
            chk_fail    = !l1_ok;
            chk_ppn     = {l1_pte[pte_ppn+10 +: 10], vaddr.walk.vpn0};
            chk_addr    = l1_addr;
            chk_wdata   = l1_pte_upd;
            chk_need_wr = (l1_pte_upd != l1_pte);
        end else if (l1_pte[pte_v] && l0_pte[pte_v] && l0_leaf) begin
            chk_fail = !l0_ok;
        end
    end

    // Everything holds while memory is busy
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else if (!mem_busy) begin
            case (state)
                st_idle: begin
                    if (translate) begin
                        state <= tlb_hit ? st_hit : st_l1_rd;
                    end
                end
                st_l1_rd:   state <= st_l1_wait;
                st_l1_wait: state <= st_l0_rd;
                // No level-0 read after an invalid or leaf level 1
                st_l0_rd:   state <= walk_re ? st_l0_wait : st_check;
                st_l0_wait: state <= st_check;
                st_check:   state <= st_update;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (!mem_busy) begin
            if (state == st_l1_wait) begin
                l1_pte <= mem_rdata;
            end
            if (state == st_l0_wait) begin
                l0_pte <= mem_rdata;
            end
            if (state == st_idle) begin
                paddr <= {tlb_ppn, vaddr.page.offset};
            end
            if (state == st_check) begin
                r_fail    <= chk_fail;
                r_need_wr <= chk_need_wr;
                r_waddr   <= chk_addr;
                r_wdata   <= chk_wdata;
                r_ppn     <= chk_ppn;
            end
        end
    end

    assign walk_re = (state == st_l1_rd) ||
                     (state == st_l0_rd && l1_pte[pte_v] && !l1_leaf);
    assign walk_we = (state == st_update) && !r_fail && r_need_wr;

    assign walk_addr  = (state == st_l1_rd) ? l1_addr :
                        (state == st_l0_rd) ? l0_addr : r_waddr;
    assign walk_wdata = r_wdata;

    // One-hot fill of the TLB for this access type
    assign fill_we  = (state == st_update && !r_fail && !mem_busy) ? (3'b001 << req_type) : 3'b000;
    assign fill_ppn = r_ppn;

    assign fault       = (state == st_update) && r_fail && !mem_busy;
    assign paddr_valid = (state == st_hit);

    // Busy ends on the hit-issue cycle or the fault cycle
    assign walk_busy = (state == st_idle) ? translate : !(state == st_hit || fault);

endmodule

/* mmu_access_ctrl.sv */
//################################################
// MMU access control
// Bare or translated address, memory port mux,
// processor busy and page-fault cause
//################################################

`timescale 1ns/100ps

module mmu_access_ctrl import mmu_pkg::*; (
    input  logic [1:0]      req_type,
    input  logic [1:0]      priv,
    input  logic [xlen-1:0] vaddr,
    input  logic [xlen-1:0] wdata,
    input  logic [xlen-1:0] satp,
    input  logic [2:0]      size,
    output logic            translate,
    input  logic [xlen-1:0] paddr,
    input  logic            paddr_valid,
    input  logic            walk_busy,
    input  logic            walk_re,
    input  logic            walk_we,
    input  logic            fault,
    input  logic [xlen-1:0] walk_addr,
    input  logic [xlen-1:0] walk_wdata,
    input  logic            mem_busy,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output logic            mem_re,
    output logic            mem_we,
    output logic [2:0]      mem_size,
    output logic            busy,
    output logic [xlen-1:0] fault_cause
);

    logic req_valid;
    logic issue;

    assign req_valid = (req_type != access_none);

    assign translate = req_valid && (priv != priv_m) && satp[satp_mode];

    // Bare requests go straight out, translated ones wait for paddr
    assign issue = req_valid && (!translate || paddr_valid) && !fault;

    always_comb begin
        if (walk_re || walk_we) begin
            mem_addr  = walk_addr;
            mem_wdata = walk_wdata;
            mem_re    = walk_re;
            mem_we    = walk_we;
            mem_size  = mem_size_word;
        end else begin
            mem_addr  = translate ? paddr : vaddr;
            mem_wdata = wdata;
            mem_re    = issue && (req_type != access_store);
            mem_we    = issue && (req_type == access_store);
            // Fetches are always whole words
            mem_size  = (req_type == access_fetch) ? mem_size_word : size;
        end
    end

    assign busy = walk_busy || mem_busy;

    always_comb begin
        fault_cause = '0;
        if (fault) begin
            case (req_type)
                access_fetch: fault_cause = cause_fetch_pf;
                access_load:  fault_cause = cause_load_pf;
                default:      fault_cause = cause_store_pf;
            endcase
        end
    end

endmodule

/* mmu_top.sv */
//################################################
// Sv32 MMU top level
// Per-access TLBs, PTE checkers, walker and
// memory port control
//################################################

`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic            CLK,
    input  logic            rst_n,
    input  logic [1:0]      req_type,
    input  logic [xlen-1:0] vaddr,
    input  logic [xlen-1:0] wdata,
    input  logic [2:0]      size,
    input  logic [1:0]      priv,
    input  logic [xlen-1:0] satp,
    input  logic [xlen-1:0] mstatus,
    input  logic            tlb_flush,
    output logic [xlen-1:0] rdata,
    output logic            busy,
    output logic            fault,
    output logic [xlen-1:0] fault_cause,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output logic            mem_we,
    output logic            mem_re,
    output logic [2:0]      mem_size,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            mem_busy
);

    sv32_vaddr_u      va;
    logic [2:0]       tlb_hits;
    logic [ppn_w-1:0] ppn_fetch;
    logic [ppn_w-1:0] ppn_load;
    logic [ppn_w-1:0] ppn_store;
    logic             tlb_hit;
    logic [ppn_w-1:0] tlb_ppn;
    logic [2:0]       fill_we;
    logic [ppn_w-1:0] fill_ppn;
    logic [xlen-1:0]  l1_pte;
    logic [xlen-1:0]  l0_pte;
    logic [xlen-1:0]  l1_pte_upd;
    logic [xlen-1:0]  l0_pte_upd;
    logic             l1_leaf;
    logic             l1_ok;
    logic             l0_leaf;
    logic             l0_ok;
    logic [xlen-1:0]  walk_addr;
    logic [xlen-1:0]  walk_wdata;
    logic             walk_re;
    logic             walk_we;
    logic [xlen-1:0]  paddr;
    logic             paddr_valid;
    logic             walk_busy;
    logic             translate;

    assign va    = vaddr;
    assign rdata = mem_rdata;

    // Hit and PPN of the TLB for this access type
    assign tlb_hit = (req_type != access_none) && tlb_hits[req_type];
    assign tlb_ppn = (req_type == access_fetch) ? ppn_fetch :
                     (req_type == access_load)  ? ppn_load  : ppn_store;

    mmu_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_fetch (
        .CLK(CLK), .rst_n(rst_n), .flush(tlb_flush), .we(fill_we[access_fetch]),
        .lookup_vpn(va.page.vpn), .fill_vpn(va.page.vpn), .fill_ppn(fill_ppn),
        .hit(tlb_hits[access_fetch]), .ppn(ppn_fetch)
    );

    mmu_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_load (
        .CLK(CLK), .rst_n(rst_n), .flush(tlb_flush), .we(fill_we[access_load]),
        .lookup_vpn(va.page.vpn), .fill_vpn(va.page.vpn), .fill_ppn(fill_ppn),
        .hit(tlb_hits[access_load]), .ppn(ppn_load)
    );

    mmu_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_store (
        .CLK(CLK), .rst_n(rst_n), .flush(tlb_flush), .we(fill_we[access_store]),
        .lookup_vpn(va.page.vpn), .fill_vpn(va.page.vpn), .fill_ppn(fill_ppn),
        .hit(tlb_hits[access_store]), .ppn(ppn_store)
    );

    mmu_pte_check check_l1 (
        .pte(l1_pte), .req_type(req_type), .priv(priv), .mstatus(mstatus),
        .is_leaf(l1_leaf), .allowed(l1_ok), .pte_updated(l1_pte_upd)
    );

    mmu_pte_check check_l0 (
        .pte(l0_pte), .req_type(req_type), .priv(priv), .mstatus(mstatus),
        .is_leaf(l0_leaf), .allowed(l0_ok), .pte_updated(l0_pte_upd)
    );

    mmu_page_walker walker (
        .CLK(CLK), .rst_n(rst_n), .req_type(req_type), .vaddr(va), .satp(satp),
        .translate(translate), .tlb_hit(tlb_hit), .tlb_ppn(tlb_ppn),
        .mem_busy(mem_busy), .mem_rdata(mem_rdata), .l1_pte(l1_pte), .l0_pte(l0_pte),
        .l1_leaf(l1_leaf), .l1_ok(l1_ok), .l0_leaf(l0_leaf), .l0_ok(l0_ok),
        .l1_pte_upd(l1_pte_upd), .l0_pte_upd(l0_pte_upd),
        .walk_addr(walk_addr), .walk_wdata(walk_wdata), .walk_re(walk_re),
        .walk_we(walk_we), .fill_we(fill_we), .fill_ppn(fill_ppn), .paddr(paddr),
        .paddr_valid(paddr_valid), .walk_busy(walk_busy), .fault(fault)
    );

    mmu_access_ctrl access_ctrl (
        .req_type(req_type), .priv(priv), .vaddr(vaddr), .wdata(wdata), .satp(satp),
        .size(size), .translate(translate), .paddr(paddr), .paddr_valid(paddr_valid),
        .walk_busy(walk_busy), .walk_re(walk_re), .walk_we(walk_we), .fault(fault),
        .walk_addr(walk_addr), .walk_wdata(walk_wdata), .mem_busy(mem_busy),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_re(mem_re), .mem_we(mem_we),
        .mem_size(mem_size), .busy(busy), .fault_cause(fault_cause)
    );

endmodule

/* tb_mmu_top.sv */
//################################################
// Testbench for the Sv32 MMU
// Random page tables in a sparse memory model,
// checked against a reference translator
//################################################

`timescale 1ns/100ps

module tb_mmu_top import mmu_pkg::*; ();

    localparam int timeout_cycles = 200;

    localparam logic [9:0] f_v = 10'h001;
    localparam logic [9:0] f_r = 10'h002;
    localparam logic [9:0] f_w = 10'h004;
    localparam logic [9:0] f_x = 10'h008;
    localparam logic [9:0] f_u = 10'h010;

    logic        CLK;
    logic        rst_n;
    logic [1:0]  req_type;
    logic [31:0] vaddr;
    logic [31:0] wdata;
    logic [2:0]  size;
    logic [1:0]  priv;
    logic [31:0] satp;
    logic [31:0] mstatus;
    logic        tlb_flush;
    logic [31:0] rdata;
    logic        busy;
    logic        fault;
    logic [31:0] fault_cause;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        mem_re;
    logic [2:0]  mem_size;
    logic [31:0] mem_rdata;
    logic        mem_busy;

    // Sparse word memory, indexed by word address
    logic [31:0] mem [logic [29:0]];
    int unsigned busy_left;
    int          errors;
    int          checks;
    logic [31:0] cur_va;
    logic [31:0] cur_satp;
    logic [31:0] cur_l0_addr;

    mmu_top #(.TLB_ENTRIES(4)) mmu_top_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Memory model with 0 to 3 busy cycles after each accepted request
    always @(posedge CLK) begin
        if (!rst_n) begin
            busy_left = 0;
        end else if (busy_left != 0) begin
            busy_left = busy_left - 1;
        end else if (mem_we) begin
            mem[mem_addr[31:2]] = mem_wdata;
            busy_left = $urandom_range(3, 0);
        end else if (mem_re) begin
            mem_rdata <= mem_word(mem_addr);
            busy_left = $urandom_range(3, 0);
        end
        mem_busy <= (busy_left != 0);
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        // Untouched words read back a pattern of their own address
        return {addr[31:2], 2'b00} ^ {addr[15:2], addr[31:14]} ^ 32'h6b2f_91c3;
    endfunction

    function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic [9:0] flags);
        return {2'b00, ppn, flags};
    endfunction

    function automatic logic [31:0] cause_for(input logic [1:0] typ);
        case (typ)
            access_fetch: return 32'd12;
            access_load:  return 32'd13;
            default:      return 32'd15;
        endcase
    endfunction

    // Reference Sv32 translation over the memory model
    function automatic void ref_translate(
        input  logic [31:0] va,
        input  logic [1:0]  typ,
        input  logic [1:0]  prv,
        input  logic [31:0] sp,
        input  logic [31:0] ms,
        output logic        flt,
        output logic [31:0] pa,
        output logic [31:0] pte_addr,
        output logic [31:0] pte_new
    );
        logic [31:0] p;
        logic        is_super;
        logic        type_ok;
        flt      = 1'b1;
        pa       = 32'h0;
        is_super = 1'b1;
        pte_addr = {sp[19:0], 12'b0} + {20'b0, va[31:22], 2'b0};
        p        = mem_word(pte_addr);
        pte_new  = p;
        if (!p[0]) begin
            return;
        end
        // X/W/R all clear means a pointer to the next level
        if (p[3:1] == 3'b000) begin
            is_super = 1'b0;
            pte_addr = {p[29:10], 12'b0} + {20'b0, va[21:12], 2'b0};
            p        = mem_word(pte_addr);
            pte_new  = p;
            if (!p[0] || p[3:1] == 3'b000) begin
                return;
            end
        end
        case (typ)
            access_fetch: type_ok = p[3];
            access_load:  type_ok = p[1] || (ms[mstatus_mxr] && p[3]);
            default:      type_ok = p[2];
        endcase
        if ((p[2] && !p[1]) || !type_ok) begin
            return;
        end
        if ((prv == priv_s && p[4] && !ms[mstatus_sum]) || (prv == priv_u && !p[4])) begin
            return;
        end
        flt     = 1'b0;
        pte_new = p | 32'h40 | ((typ == access_store) ? 32'h80 : 32'h0);
        pa      = is_super ? {p[29:20], va[21:0]} : {p[29:10], va[11:0]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic set_ctx(input logic [1:0] prv, input logic [31:0] sp, input logic [31:0] ms);
        @(posedge CLK);
        priv    <= prv;
        satp    <= sp;
        mstatus <= ms;
    endtask

    task automatic flush_tlbs();
        @(posedge CLK);
        tlb_flush <= 1'b1;
        @(posedge CLK);
        tlb_flush <= 1'b0;
    endtask

    // First later cycle with memory not busy carries the read data
    task automatic wait_mem_idle(output logic [31:0] rd);
        int n;
        n  = 0;
        rd = 32'h0;
        do begin
            @(posedge CLK);
            n++;
        end while (mem_busy && n < timeout_cycles);
        if (mem_busy) begin
            errors++;
            $display("Timeout: memory stayed busy after an access");
        end
        rd = rdata;
    endtask

    task automatic do_access(
        input  logic [1:0]  typ,
        input  logic [31:0] va,
        input  logic [31:0] wd,
        output logic        flt,
        output logic [31:0] cause,
        output logic [31:0] addr,
        output logic [31:0] rd
    );
        int         n;
        logic       done;
        logic [2:0] sz;
        flt   = 1'b0;
        cause = 32'h0;
        addr  = 32'h0;
        rd    = 32'h0;
        done  = 1'b0;
        n     = 0;
        // Fetches are presented as whole words
        sz    = (typ == access_fetch) ? mem_size_word : 3'($urandom % 3);
        @(posedge CLK);
        req_type <= typ;
        vaddr    <= va;
        wdata    <= wd;
        size     <= sz;
        while (!done && n < timeout_cycles) begin
            @(posedge CLK);
            n++;
            if (fault) begin
                flt   = 1'b1;
                cause = fault_cause;
                check_val("mem_we", 32'(mem_we), 32'h0);
                done  = 1'b1;
            end else if (!busy) begin
                addr = mem_addr;
                check_val("mem_we", 32'(mem_we), 32'(typ == access_store));
                check_val("mem_re", 32'(mem_re), 32'(typ != access_store));
                check_val("mem_size", 32'(mem_size), 32'(sz));
                done = 1'b1;
            end
        end
        req_type <= access_none;
        if (!done) begin
            errors++;
            $display("Timeout: request to %h was neither performed nor faulted", va);
        end else if (!flt) begin
            wait_mem_idle(rd);
        end
    endtask

    // Root table, level-0 table and data page all land in separate regions
    task automatic build_map(input logic [9:0] l1f, input logic [9:0] l0f);
        logic [19:0] root;
        logic [19:0] tab_ppn;
        logic [19:0] dppn;
        logic [31:0] l1_addr;
        root        = 20'h10000 | 20'($urandom % 256);
        tab_ppn     = 20'h20000 | 20'($urandom % 256);
        dppn        = 20'h40000 | 20'($urandom % 65536);
        cur_va      = $urandom & 32'hffff_fffc;
        cur_satp    = {1'b1, 11'b0, root};
        l1_addr     = {root, 12'b0} + {20'b0, cur_va[31:22], 2'b0};
        cur_l0_addr = {tab_ppn, 12'b0} + {20'b0, cur_va[21:12], 2'b0};
        if (l1f[3:1] != 3'b000) begin
            mem[l1_addr[31:2]] = make_pte({dppn[19:10], 10'b0}, l1f);
        end else begin
            mem[l1_addr[31:2]] = make_pte(tab_ppn, l1f);
        end
        mem[cur_l0_addr[31:2]] = make_pte(dppn, l0f);
    endtask

    task automatic run_mapped(
        input logic [1:0]  typ,
        input logic [1:0]  prv,
        input logic [31:0] ms,
        input logic        want_fault
    );
        logic        e_flt;
        logic [31:0] e_pa;
        logic [31:0] e_pte_addr;
        logic [31:0] e_pte;
        logic [31:0] exp_rd;
        logic [31:0] wd;
        logic        flt;
        logic [31:0] cause;
        logic [31:0] addr;
        logic [31:0] rd;
        set_ctx(prv, cur_satp, ms);
        ref_translate(cur_va, typ, prv, cur_satp, ms, e_flt, e_pa, e_pte_addr, e_pte);
        check_val("model fault", 32'(e_flt), 32'(want_fault));
        exp_rd = mem_word(e_pa);
        wd     = $urandom;
        do_access(typ, cur_va, wd, flt, cause, addr, rd);
        check_val("fault", 32'(flt), 32'(e_flt));
        if (e_flt) begin
            check_val("fault_cause", cause, cause_for(typ));
        end else begin
            check_val("mem_addr", addr, e_pa);
            if (typ == access_store) begin
                check_val("stored word", mem_word(e_pa), wd);
            end else begin
                check_val("rdata", rd, exp_rd);
            end
        end
        check_val("pte", mem_word(e_pte_addr), e_pte);
    endtask

    task automatic map_and_access(
        input logic [9:0]  l1f,
        input logic [9:0]  l0f,
        input logic [1:0]  typ,
        input logic [1:0]  prv,
        input logic [31:0] ms,
        input logic        want_fault
    );
        flush_tlbs();
        build_map(l1f, l0f);
        run_mapped(typ, prv, ms, want_fault);
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_bare();
        int          start;
        logic [1:0]  typ;
        logic [31:0] va;
        logic [31:0] wd;
        logic [31:0] exp_rd;
        logic        flt;
        logic [31:0] cause;
        logic [31:0] addr;
        logic [31:0] rd;
        start = errors;
        repeat (16) begin
            typ = 2'($urandom % 3);
            va  = $urandom & 32'hffff_fffc;
            wd  = $urandom;
            if ($urandom % 2 == 0) begin
                set_ctx(priv_m, $urandom | 32'h8000_0000, 32'h0);
            end else begin
                set_ctx(2'($urandom % 2), $urandom & 32'h7fff_ffff, 32'h0);
            end
            exp_rd = mem_word(va);
            do_access(typ, va, wd, flt, cause, addr, rd);
            check_val("fault", 32'(flt), 32'h0);
            check_val("mem_addr", addr, va);
            if (typ == access_store) begin
                check_val("stored word", mem_word(va), wd);
            end else begin
                check_val("rdata", rd, exp_rd);
            end
        end
        report_test("bare mode", start);
    endtask

    task automatic test_4k();
        int   start;
        logic user;
        start = errors;
        repeat (12) begin
            user = 1'($urandom % 2);
            map_and_access(f_v, f_v | f_r | (user ? f_u : 10'h0), access_load,
                           user ? priv_u : priv_s, 32'h0, 1'b0);
        end
        report_test("4 KiB translation", start);
    endtask

    task automatic test_superpage();
        int start;
        start = errors;
        repeat (8) begin
            map_and_access(f_v | f_r | f_w, 10'h0, access_store, priv_s, 32'h0, 1'b0);
        end
        report_test("superpage store", start);
    endtask

    task automatic test_faults();
        int start;
        start = errors;
        map_and_access(f_v, f_r, access_load, priv_s, 32'h0, 1'b1);
        map_and_access(10'h0, f_v | f_r, access_fetch, priv_s, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_w, access_store, priv_s, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_w | f_x, access_load, priv_s, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_r | f_u, access_load, priv_s, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_r | f_u, access_load, priv_s, 32'h1 << mstatus_sum, 1'b0);
        map_and_access(f_v, f_v | f_r, access_store, priv_s, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_x, access_load, priv_s, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_x, access_load, priv_s, 32'h1 << mstatus_mxr, 1'b0);
        map_and_access(f_v, f_v | f_r, access_load, priv_u, 32'h0, 1'b1);
        map_and_access(f_v, f_v | f_x, access_fetch, priv_s, 32'h0, 1'b0);
        report_test("page faults", start);
    endtask

    task automatic test_tlb_reuse();
        int          start;
        logic        flt;
        logic [31:0] old_pa;
        logic [31:0] pte_addr;
        logic [31:0] pte_new;
        logic [31:0] cause;
        logic [31:0] addr;
        logic [31:0] rd;
        start = errors;
        map_and_access(f_v, f_v | f_r, access_load, priv_s, 32'h0, 1'b0);
        ref_translate(cur_va, access_load, priv_s, cur_satp, 32'h0, flt, old_pa, pte_addr, pte_new);
        // New mapping is only seen once the TLBs are flushed
        mem[cur_l0_addr[31:2]] = make_pte(20'h50000 | 20'($urandom % 65536), f_v | f_r);
        do_access(access_load, cur_va, 32'h0, flt, cause, addr, rd);
        check_val("fault", 32'(flt), 32'h0);
        check_val("mem_addr", addr, old_pa);
        flush_tlbs();
        run_mapped(access_load, priv_s, 32'h0, 1'b0);
        report_test("TLB reuse and flush", start);
    endtask

    initial begin
        void'($urandom(32'h871c));
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        req_type  = access_none;
        vaddr     = 32'h0;
        wdata     = 32'h0;
        size      = mem_size_word;
        priv      = priv_m;
        satp      = 32'h0;
        mstatus   = 32'h0;
        tlb_flush = 1'b0;
        mem_rdata = 32'h0;
        mem_busy  = 1'b0;
        repeat (2) @(posedge CLK);
        rst_n <= 1'b1;
        test_bare();
        test_4k();
        test_superpage();
        test_faults();
        test_tlb_reuse();
        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* project.f */
mmu_pkg.sv
mmu_tlb.sv
mmu_pte_check.sv
mmu_page_walker.sv
mmu_access_ctrl.sv
mmu_top.sv
tb_mmu_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_mmu_top
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
